// ==== logic/ddr_ctrl_pkg.sv ====
package ddr_ctrl_pkg;

	// memory command encoding
	typedef enum logic [2:0] {
		NOOP = 3'd0,
		ACTV = 3'd1,
		READ = 3'd2,
		WRTE = 3'd3,
		PRCH = 3'd4,
		AREF = 3'd5
	} dram_cmd_e;

	// user access address, row in the top bits
	typedef struct packed {
		logic [12:0] row;
		logic [1:0]  bank;
		logic [12:0] col;
	} dram_addr_t;

	// registered command bus towards the DRAM
	typedef struct packed {
		dram_cmd_e   cmd;
		logic [1:0]  bank;
		logic [12:0] addr;
	} dram_bus_t;

	// wait after each command, in cycles
	localparam logic [3:0] GAP_ACTV = 4'd2;
	localparam logic [3:0] GAP_RW   = 4'd3;
	localparam logic [3:0] GAP_PRCH = 4'd3;
	localparam logic [3:0] GAP_AREF = 4'd15;

	// A10 high on PRCH closes every bank
	localparam logic [12:0] PRCH_ALL_ADDR = 13'h0400;

endpackage

// ==== logic/cmd_gap_timer.sv ====
module cmd_gap_timer (
	input  logic       CLK,
	input  logic       RST,
	input  logic       load,
	input  logic [3:0] gap_val,
	output logic       expired
);

	logic [3:0] cnt;

	assign expired = (cnt == 4'hf);

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			cnt <= 4'hf; // free to issue right away
		end
		else if (load)
		begin
			cnt <= 4'hf - gap_val;
		end
		else if (!expired)
		begin
			cnt <= cnt + 4'd1; // saturates at 15
		end
	end

	// the FSM may only issue once the previous gap is over
	a_load_when_expired: assert property (
		@(posedge CLK) disable iff (!RST)
		load |-> expired
	);

endmodule

// ==== logic/bank_state_fsm.sv ====
module bank_state_fsm
	import ddr_ctrl_pkg::*;
(
	input  logic      CLK,
	input  logic      RST,
	input  logic      want_issue,
	input  dram_cmd_e next_cmd,
	output logic      issue_ok,
	output logic      issued,
	output logic      page_open
);

	dram_cmd_e  last_cmd;
	logic       expired;
	logic [3:0] gap_val;

	assign issue_ok = expired;
	assign issued   = want_issue && issue_ok;

	always_comb
	begin
		case (next_cmd)
			ACTV:       gap_val = GAP_ACTV;
			READ, WRTE: gap_val = GAP_RW;
			PRCH:       gap_val = GAP_PRCH;
			AREF:       gap_val = GAP_AREF;
			default:    gap_val = 4'd0;
		endcase
	end

	cmd_gap_timer u_gap_timer (
		.CLK     (CLK),
		.RST     (RST),
		.load    (issued),
		.gap_val (gap_val),
		.expired (expired)
	);

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			last_cmd  <= NOOP;
			page_open <= 1'b0;
		end
		else if (issued)
		begin
			last_cmd <= next_cmd;
			if (next_cmd == ACTV)
			begin
				page_open <= 1'b1;
			end
			else if (next_cmd == PRCH)
			begin
				page_open <= 1'b0;
			end
		end
	end

	// a page is always closed before a new one is opened
	a_no_actv_on_open: assert property (
		@(posedge CLK) disable iff (!RST)
		(issued && next_cmd == ACTV) |-> !page_open
	);

	// refresh only ever follows the precharge of its own sequence
	a_aref_after_prch: assert property (
		@(posedge CLK) disable iff (!RST)
		(issued && next_cmd == AREF) |-> (last_cmd == PRCH)
	);

endmodule

// ==== logic/cmd_sequencer.sv ====
module cmd_sequencer
	import ddr_ctrl_pkg::*;
(
	input  logic       CLK,
	input  logic       RST,
	input  logic       acc_stb,
	input  dram_addr_t acc_addr,
	input  logic       acc_we,
	input  logic       ref_toggle,
	input  logic       page_open,
	input  logic       issue_ok,
	input  logic       issued,
	output logic       want_issue,
	output dram_cmd_e  next_cmd,
	output logic       idle,
	output dram_bus_t  mem_bus,
	output logic       seq_we
);

	dram_cmd_e   cmd_q [3];
	logic [1:0]  slot_cnt;
	dram_addr_t  acc_q;
	logic        we_q;
	logic [12:0] open_row;
	logic [1:0]  open_bank;
	logic        ref_ack;
	logic        ref_pend;
	logic        hit;
	dram_cmd_e   rw_cmd;
	dram_cmd_e   bus_cmd;
	logic [1:0]  bus_bank;
	logic [12:0] bus_addr;

	assign ref_pend   = ref_toggle ^ ref_ack;
	assign idle       = (slot_cnt == 2'd0) && !ref_pend; // pending refresh blocks access
	assign want_issue = (slot_cnt != 2'd0);
	assign next_cmd   = cmd_q[0];
	assign seq_we     = we_q;
	assign rw_cmd     = acc_we ? WRTE : READ;
	assign hit        = page_open && (acc_addr.row == open_row) &&
	                    (acc_addr.bank == open_bank);
	assign mem_bus    = '{cmd: bus_cmd, bank: bus_bank, addr: bus_addr};

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			cmd_q[0] <= NOOP;
			cmd_q[1] <= NOOP;
			cmd_q[2] <= NOOP;
			slot_cnt <= 2'd0;
			ref_ack  <= ref_toggle; // current level counts as seen
			we_q     <= 1'b0;
		end
		else if (issued)
		begin
			cmd_q[0] <= cmd_q[1];
			cmd_q[1] <= cmd_q[2];
			cmd_q[2] <= NOOP;
			slot_cnt <= slot_cnt - 2'd1;
		end
		else if (slot_cnt == 2'd0 && ref_pend)
		begin
			cmd_q[0] <= PRCH;
			cmd_q[1] <= AREF;
			cmd_q[2] <= NOOP;
			slot_cnt <= 2'd2;
			ref_ack  <= ref_toggle;
		end
		else if (acc_stb && idle)
		begin
			we_q <= acc_we;
			if (hit)
			begin
				cmd_q[0] <= rw_cmd;
				cmd_q[1] <= NOOP;
				cmd_q[2] <= NOOP;
				slot_cnt <= 2'd1;
			end
			else
			begin
				cmd_q[0] <= PRCH;
				cmd_q[1] <= ACTV;
				cmd_q[2] <= rw_cmd;
				slot_cnt <= 2'd3;
			end
		end
	end

	// address and page registers
	always_ff @(posedge CLK)
	begin
		if (acc_stb && idle)
		begin
			acc_q <= acc_addr;
		end
		if (issued && next_cmd == ACTV)
		begin
			open_row  <= acc_q.row;
			open_bank <= acc_q.bank;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			bus_cmd <= NOOP;
		end
		else
		begin
			bus_cmd <= issued ? next_cmd : NOOP; // one cycle per command
		end
	end

	always_ff @(posedge CLK)
	begin
		if (want_issue && issue_ok)
		begin
			bus_bank <= acc_q.bank;
			case (next_cmd)
				PRCH:       bus_addr <= PRCH_ALL_ADDR;
				ACTV:       bus_addr <= acc_q.row;
				READ, WRTE: bus_addr <= acc_q.col;
				default:    bus_addr <= 13'h0;
			endcase
		end
	end

	// count never runs past the queued commands
	a_slot_no_underflow: assert property (
		@(posedge CLK) disable iff (!RST)
		issued |-> (next_cmd != NOOP)
	);

endmodule

// ==== logic/data_path.sv ====
module data_path
	import ddr_ctrl_pkg::*;
#(
	parameter int DATA_W = 32,
	parameter int RD_LAT = 2
) (
	input  logic              CLK,
	input  logic              RST,
	input  logic              issued,
	input  dram_cmd_e         issued_cmd,
	input  logic [DATA_W-1:0] wdata,
	input  logic [DATA_W-1:0] mem_dq_in,
	output logic [DATA_W-1:0] mem_dq_out,
	output logic              mem_dq_oe,
	output logic [DATA_W-1:0] rd_data,
	output logic              rd_valid
);

	logic              rd_on_bus;
	logic [RD_LAT-1:0] rd_pipe;

	// write side, lines up with WRTE on the bus
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			mem_dq_oe <= 1'b0;
			rd_on_bus <= 1'b0;
		end
		else
		begin
			mem_dq_oe <= issued && (issued_cmd == WRTE);
			rd_on_bus <= issued && (issued_cmd == READ); // READ cycle marker
		end
	end

	always_ff @(posedge CLK)
	begin
		if (issued && issued_cmd == WRTE)
		begin
			mem_dq_out <= wdata;
		end
	end

	// read marker travels RD_LAT cycles behind the READ
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			rd_pipe  <= '0;
			rd_valid <= 1'b0;
		end
		else
		begin
			rd_pipe[0] <= rd_on_bus;
			for (int i = 1; i < RD_LAT; i++)
			begin
				rd_pipe[i] <= rd_pipe[i-1];
			end
			rd_valid <= rd_pipe[RD_LAT-1];
		end
	end

	always_ff @(posedge CLK)
	begin
		if (rd_pipe[RD_LAT-1])
		begin
			rd_data <= mem_dq_in; // sample as the marker arrives
		end
	end

endmodule

// ==== logic/ddr_ctrl_top.sv ====
module ddr_ctrl_top
	import ddr_ctrl_pkg::*;
#(
	parameter int DATA_W = 32,
	parameter int RD_LAT = 2
) (
	input  logic              CLK,
	input  logic              RST,
	input  logic              acc_stb,
	input  dram_addr_t        acc_addr,
	input  logic              acc_we,
	input  logic [DATA_W-1:0] acc_wdata,
	input  logic              ref_toggle,
	input  logic [DATA_W-1:0] mem_dq_in,
	output logic              idle,
	output dram_bus_t         mem_bus,
	output logic [DATA_W-1:0] mem_dq_out,
	output logic              mem_dq_oe,
	output logic [DATA_W-1:0] rd_data,
	output logic              rd_valid
);

	logic      want_issue;
	logic      issue_ok;
	logic      issued;
	logic      page_open;
	dram_cmd_e next_cmd;

	bank_state_fsm u_bank_state (
		.CLK        (CLK),
		.RST        (RST),
		.want_issue (want_issue),
		.next_cmd   (next_cmd),
		.issue_ok   (issue_ok),
		.issued     (issued),
		.page_open  (page_open)
	);

	cmd_sequencer u_sequencer (
		.CLK        (CLK),
		.RST        (RST),
		.acc_stb    (acc_stb),
		.acc_addr   (acc_addr),
		.acc_we     (acc_we),
		.ref_toggle (ref_toggle),
		.page_open  (page_open),
		.issue_ok   (issue_ok),
		.issued     (issued),
		.want_issue (want_issue),
		.next_cmd   (next_cmd),
		.idle       (idle),
		.mem_bus    (mem_bus),
		.seq_we     ()
	);

	data_path #(
		.DATA_W (DATA_W),
		.RD_LAT (RD_LAT)
	) u_data_path (
		.CLK        (CLK),
		.RST        (RST),
		.issued     (issued),
		.issued_cmd (next_cmd),
		.wdata      (acc_wdata),
		.mem_dq_in  (mem_dq_in),
		.mem_dq_out (mem_dq_out),
		.mem_dq_oe  (mem_dq_oe),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid)
	);

endmodule

// ==== test/ddr_checker.sv ====
module ddr_checker
	import ddr_ctrl_pkg::*;
#(
	parameter int DATA_W = 32,
	parameter int RD_LAT = 2
) (
	input logic              CLK,
	input logic              RST,
	input logic              acc_stb,
	input dram_addr_t        acc_addr,
	input logic              acc_we,
	input logic [DATA_W-1:0] acc_wdata,
	input logic              ref_toggle,
	input logic              idle,
	input dram_bus_t         mem_bus,
	input logic [DATA_W-1:0] mem_dq_out,
	input logic              mem_dq_oe,
	input logic [DATA_W-1:0] rd_data,
	input logic              rd_valid,
	input logic [DATA_W-1:0] exp_rdata,
	input int                op_idx
);

	typedef struct packed {
		dram_cmd_e   cmd;
		logic        chk_bank;
		logic [1:0]  bank;
		logic        chk_addr;
		logic [12:0] addr;
	} exp_cmd_t;

	exp_cmd_t          exp_q [$];
	int                rd_due [$];
	logic [DATA_W-1:0] rd_exp [$];
	int                err_mismatch = 0;
	int                err_other = 0;
	int                cycle = 0;
	int                last_cyc = -100;
	int                last_gap = 0;
	logic              ref_seen;
	logic              pg_open = 1'b0;
	logic [12:0]       pg_row;
	logic [1:0]        pg_bank;
	logic [DATA_W-1:0] cur_wdata;
	logic [DATA_W-1:0] cur_rexp;
	logic              exp_idle;

	task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
		$display("Mismatch op%0d %s: expected %h, actual %h", op_idx, what, exp, act);
		err_mismatch++;
	endtask

	task automatic complain(input string msg);
		$display("Error: op%0d %s", op_idx, msg);
		err_other++;
	endtask

	function automatic int gap_of(input dram_cmd_e c);
		case (c)
			ACTV:       return int'(GAP_ACTV);
			READ, WRTE: return int'(GAP_RW);
			PRCH:       return int'(GAP_PRCH);
			default:    return int'(GAP_AREF);
		endcase
	endfunction

	task automatic check_drained();
		if (exp_q.size() != 0)
			complain("expected commands never showed up on the bus");
		if (rd_due.size() != 0)
			complain("a read never returned its data");
	endtask

	task automatic check_cmd();
		exp_cmd_t e;
		if (exp_q.size() == 0)
		begin
			complain("a command appeared on the bus that nothing asked for");
			return;
		end
		e = exp_q.pop_front();
		if (mem_bus.cmd != e.cmd)
			mismatch("command", 32'(e.cmd), 32'(mem_bus.cmd));
		if (e.chk_bank && mem_bus.bank != e.bank)
			mismatch("bank", 32'(e.bank), 32'(mem_bus.bank));
		if (e.chk_addr && mem_bus.addr != e.addr)
			mismatch("address", 32'(e.addr), 32'(mem_bus.addr));
		if (cycle - last_cyc < last_gap + 1)
			complain($sformatf("command came %0d cycles after the last one", cycle - last_cyc));
		last_cyc = cycle;
		last_gap = gap_of(mem_bus.cmd);
		if (mem_bus.cmd == READ)
		begin
			rd_due.push_back(cycle + RD_LAT + 1);
			rd_exp.push_back(cur_rexp);
		end
	endtask

	always @(negedge CLK)
	begin
		if (!RST)
		begin
			ref_seen = ref_toggle;
			if (mem_bus.cmd != NOOP || !idle || rd_valid || mem_dq_oe)
				complain("outputs are not at their reset values");
		end
		else
		begin
			cycle++;
			// a new access can land in the cycle of the last command
			if (mem_bus.cmd != NOOP)
				check_cmd();
			if (mem_dq_oe != (mem_bus.cmd == WRTE))
				complain("data output enable does not line up with a WRTE");
			if (mem_bus.cmd == WRTE && mem_dq_out != cur_wdata)
				mismatch("write data", cur_wdata, mem_dq_out);
			if (rd_valid)
			begin
				if (rd_due.size() == 0)
					complain("read data came back with no read outstanding");
				else
				begin
					if (cycle != rd_due[0])
						mismatch("read latency", 32'(rd_due[0]), 32'(cycle));
					if (rd_data != rd_exp[0])
						mismatch("read data", rd_exp[0], rd_data);
					void'(rd_due.pop_front());
					void'(rd_exp.pop_front());
				end
			end
			exp_idle = (exp_q.size() == 0) && (ref_toggle == ref_seen);
			if (idle != exp_idle)
				mismatch("idle", 32'(exp_idle), 32'(idle));
			if (ref_toggle != ref_seen)
			begin
				ref_seen = ref_toggle;
				pg_open = 1'b0;
				exp_q.push_back('{PRCH, 1'b0, 2'd0, 1'b1, PRCH_ALL_ADDR});
				exp_q.push_back('{AREF, 1'b0, 2'd0, 1'b0, 13'd0});
			end
			else if (acc_stb && idle)
			begin
				cur_wdata = acc_wdata;
				cur_rexp  = exp_rdata;
				if (!(pg_open && pg_row == acc_addr.row && pg_bank == acc_addr.bank))
				begin
					exp_q.push_back('{PRCH, 1'b0, 2'd0, 1'b1, PRCH_ALL_ADDR});
					exp_q.push_back('{ACTV, 1'b1, acc_addr.bank, 1'b1, acc_addr.row});
					pg_open = 1'b1;
					pg_row  = acc_addr.row;
					pg_bank = acc_addr.bank;
				end
				exp_q.push_back('{acc_we ? WRTE : READ, 1'b1, acc_addr.bank, 1'b1, acc_addr.col});
			end
		end
	end

endmodule

// ==== test/tb_ddr_ctrl.sv ====
module tb_ddr_ctrl
	import ddr_ctrl_pkg::*;
;

	localparam int DATA_W = 32;
	localparam int RD_LAT = 2;

	logic              CLK;
	logic              RST;
	logic              acc_stb;
	dram_addr_t        acc_addr;
	logic              acc_we;
	logic [DATA_W-1:0] acc_wdata;
	logic              ref_toggle;
	logic [DATA_W-1:0] mem_dq_in;
	logic              idle;
	dram_bus_t         mem_bus;
	logic [DATA_W-1:0] mem_dq_out;
	logic              mem_dq_oe;
	logic [DATA_W-1:0] rd_data;
	logic              rd_valid;
	logic [DATA_W-1:0] exp_rdata;
	int                op_idx;

	string             op_kind [$];
	logic [27:0]       op_addr [$];
	logic [DATA_W-1:0] op_wdata [$];
	logic [DATA_W-1:0] op_rexp [$];
	int                limit;
	logic              limit_set;
	int                cycles;
	int                file_err;

	logic [DATA_W-1:0] mem [logic [27:0]];
	logic [12:0]       act_row;
	logic [1:0]        act_bank;
	logic [27:0]       rd_key [RD_LAT+1];
	logic              rd_vld [RD_LAT+1];

	ddr_ctrl_top #(
		.DATA_W (DATA_W),
		.RD_LAT (RD_LAT)
	) dut (
		.CLK        (CLK),
		.RST        (RST),
		.acc_stb    (acc_stb),
		.acc_addr   (acc_addr),
		.acc_we     (acc_we),
		.acc_wdata  (acc_wdata),
		.ref_toggle (ref_toggle),
		.mem_dq_in  (mem_dq_in),
		.idle       (idle),
		.mem_bus    (mem_bus),
		.mem_dq_out (mem_dq_out),
		.mem_dq_oe  (mem_dq_oe),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid)
	);

	ddr_checker #(
		.DATA_W (DATA_W),
		.RD_LAT (RD_LAT)
	) chk (
		.CLK        (CLK),
		.RST        (RST),
		.acc_stb    (acc_stb),
		.acc_addr   (acc_addr),
		.acc_we     (acc_we),
		.acc_wdata  (acc_wdata),
		.ref_toggle (ref_toggle),
		.idle       (idle),
		.mem_bus    (mem_bus),
		.mem_dq_out (mem_dq_out),
		.mem_dq_oe  (mem_dq_oe),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid),
		.exp_rdata  (exp_rdata),
		.op_idx     (op_idx)
	);

	initial
	begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// memory model, looks at the bus just after each edge
	always @(posedge CLK)
	begin
		#2;
		for (int i = RD_LAT; i > 0; i--)
		begin
			rd_vld[i] = rd_vld[i-1];
			rd_key[i] = rd_key[i-1];
		end
		rd_vld[0] = (RST && mem_bus.cmd == READ);
		rd_key[0] = {act_bank, act_row, mem_bus.addr};
		if (RST && mem_bus.cmd == ACTV)
		begin
			act_row  = mem_bus.addr;
			act_bank = mem_bus.bank;
		end
		if (RST && mem_bus.cmd == WRTE)
		begin
			mem[{act_bank, act_row, mem_bus.addr}] = mem_dq_out;
		end
		if (rd_vld[RD_LAT])
		begin
			if (mem.exists(rd_key[RD_LAT]))
			begin
				mem_dq_in = mem[rd_key[RD_LAT]];
			end
			else
			begin
				mem_dq_in = 32'hA000_0000 ^ {4'h0, rd_key[RD_LAT]}; // fill pattern
			end
		end
	end

	task automatic wait_idle();
		while (!idle)
		begin
			@(posedge CLK);
			#2;
		end
	endtask

	task automatic issue_access(input logic we, input logic [27:0] addr,
		input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] rexp, input int idx);
		wait_idle();
		acc_stb   = 1'b1;
		acc_addr  = addr;
		acc_we    = we;
		acc_wdata = wdata; // held until the next access
		exp_rdata = rexp;
		op_idx    = idx;
		@(posedge CLK);
		#2;
		acc_stb = 1'b0;
	endtask

	task automatic toggle_refresh(input int idx);
		wait_idle();
		op_idx     = idx;
		ref_toggle = ~ref_toggle;
		@(posedge CLK);
		#2;
	endtask

	task automatic load_ops();
		int          fd;
		int          n;
		string       line;
		string       kind;
		logic [27:0] a;
		logic [31:0] w;
		logic [31:0] e;
		fd = $fopen("test/ddr_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("Error: cannot open the stimulus file test/ddr_stimulus.txt");
			file_err = 1;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line[0] != "#")
			begin
				n = $sscanf(line, "%s %h %h %h", kind, a, w, e);
				if (n == 4)
				begin
					op_kind.push_back(kind);
					op_addr.push_back(a);
					op_wdata.push_back(w);
					op_rexp.push_back(e);
				end
			end
		end
		$fclose(fd);
	endtask

	initial
	begin
		limit_set = 1'b0;
		cycles    = 0;
		wait (limit_set);
		while (cycles < limit)
		begin
			@(posedge CLK);
			cycles++;
		end
		$display("Error: run did not finish within %0d cycles", limit);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		RST        = 1'b0;
		acc_stb    = 1'b0;
		acc_addr   = '0;
		acc_we     = 1'b0;
		acc_wdata  = '0;
		ref_toggle = 1'b0;
		mem_dq_in  = '0;
		exp_rdata  = '0;
		op_idx     = 0;
		act_row    = '0;
		act_bank   = '0;
		file_err   = 0;
		for (int i = 0; i <= RD_LAT; i++)
		begin
			rd_vld[i] = 1'b0;
			rd_key[i] = '0;
		end
		load_ops();
		limit     = 40 * op_kind.size() + 100;
		limit_set = 1'b1;
		repeat (2) @(posedge CLK);
		#2;
		RST = 1'b1;
		for (int i = 0; i < op_kind.size(); i++)
		begin
			if (op_kind[i] == "W")
				issue_access(1'b1, op_addr[i], op_wdata[i], '0, i);
			else if (op_kind[i] == "R")
				issue_access(1'b0, op_addr[i], op_wdata[i], op_rexp[i], i);
			else
				toggle_refresh(i);
		end
		wait_idle();
		repeat (RD_LAT + 2) @(posedge CLK); // let the last read come back
		chk.check_drained();
		$display("errors: %0d mismatch, %0d other, %0d setup",
			chk.err_mismatch, chk.err_other, file_err);
		if (chk.err_mismatch + chk.err_other + file_err == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== test/ddr_stimulus.txt ====
# kind (W write, R read, F refresh toggle), address {row,bank,col} hex,
# write data hex, expected read data hex
W 002A010 11111111 00000000
W 002A011 22222222 00000000
R 002A010 00000000 11111111
R 002A011 00000000 22222222
W 003A010 33333333 00000000
R 002A010 00000000 11111111
F 0000000 00000000 00000000
R 002A011 00000000 22222222
W 002C010 44444444 00000000
R 003A010 00000000 33333333
W FFFFFFF 5A5AA5A5 00000000
R FFFFFFF 00000000 5A5AA5A5
W 002A010 66666666 00000000
R 002A010 00000000 66666666
F 0000000 00000000 00000000
R 002C010 00000000 44444444
R FFFFFFF 00000000 5A5AA5A5
W 002C010 77777777 00000000
R 002C010 00000000 77777777
R 002A011 00000000 22222222
F 0000000 00000000 00000000
F 0000000 00000000 00000000
R 002A010 00000000 66666666

// ==== filelist.f ====
logic/ddr_ctrl_pkg.sv
logic/cmd_gap_timer.sv
logic/bank_state_fsm.sv
logic/cmd_sequencer.sv
logic/data_path.sv
logic/ddr_ctrl_top.sv
test/ddr_checker.sv
test/tb_ddr_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f filelist.f --top-module tb_ddr_ctrl -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_ddr_ctrl)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
